/* design/cmd_assembler.sv */
/*
 Command assembler between the UART receiver and the host.
 Takes an opcode byte then an argument byte, acknowledging each with
 clr_rdy, and offers the pair as one cmd word under four-phase req/ack.
 No byte is acknowledged while the handshake runs, so one byte can wait
 in the receiver.
*/
`timescale 1ns/1ps

module cmd_assembler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_byte_t rx_data,  // From receiver
    input  logic                 rdy,
    output logic                 clr_rdy,  // One-cycle pulse per byte taken
    output cmd_pkg::cmd_t        cmd,      // Stable while cmd_req or cmd_ack
    output logic                 cmd_req,
    input  logic                 cmd_ack
);

    // Two byte collection, then the four handshake phases
    typedef enum logic [1:0] {WAIT_OP, WAIT_ARG, OFFER, RELEASE} state_t;
    state_t state, nxt_state;

    logic take_op;   // Opcode byte accepted this cycle
    logic take_arg;  // Argument byte accepted this cycle

    assign take_op  = (state == WAIT_OP)  && rdy;
    assign take_arg = (state == WAIT_ARG) && rdy;
    assign clr_rdy  = take_op || take_arg;  // Never during OFFER or RELEASE
    assign cmd_req  = (state == OFFER);     // One cycle after arg rdy

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= WAIT_OP;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            WAIT_OP:  if (rdy) nxt_state = WAIT_ARG;
            WAIT_ARG: if (rdy) nxt_state = OFFER;
            OFFER:    if (cmd_ack) nxt_state = RELEASE;   // Host has it, drop req
            RELEASE:  if (!cmd_ack) nxt_state = WAIT_OP;  // Both low, cmd may change
            default:  nxt_state = WAIT_OP;
        endcase
    end

    // Command word, only written while no handshake is open
    always_ff @(posedge clk) begin
        if (take_op)
            cmd.op <= cmd_pkg::cmd_op_t'(rx_data);
        if (take_arg)
            cmd.arg <= cmd_pkg::cmd_arg_t'(rx_data);
    end

endmodule

/* design/cmd_pkg.sv */
/*
 Host side word formats for the UART command link.
 A command is two bytes from the line, opcode first, presented as one
 16-bit word. A response is a single byte going back out.
*/
package cmd_pkg;

    // First byte received
    typedef logic [7:0] cmd_op_t;

    // Second byte received
    typedef logic [7:0] cmd_arg_t;

    // Command word as seen by the host, op in the high byte
    typedef struct packed {
        cmd_op_t  op;   // Bits 15:8
        cmd_arg_t arg;  // Bits 7:0
    } cmd_t;

    // Response byte from the host
    typedef logic [7:0] resp_t;

endpackage

/* design/resp_sender.sv */
/*
 Response sender between the host and the UART transmitter.
 Accepts a response byte under four-phase req/ack, hands it to the
 transmitter with a one-cycle trmt and raises resp_ack once tx_done
 reports the frame is out. resp_ack falls after the host drops resp_req.
*/
`timescale 1ns/1ps

module resp_sender (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cmd_pkg::resp_t       resp,      // Stable while resp_req is high
    input  logic                 resp_req,
    output logic                 resp_ack,
    output uart_pkg::uart_byte_t tx_data,   // To transmitter
    output logic                 trmt,      // One-cycle frame start
    input  logic                 tx_done    // Held high after each frame
);

    // SEND lasts one cycle, DONE waits on the line, RELEASE holds ack
    typedef enum logic [1:0] {IDLE, SEND, DONE, RELEASE} state_t;
    state_t state, nxt_state;

    assign trmt     = (state == SEND);
    assign resp_ack = (state == RELEASE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE:    if (resp_req) nxt_state = SEND;
            SEND:    nxt_state = DONE;  // trmt clears the old tx_done here
            DONE:    if (tx_done) nxt_state = RELEASE;
            RELEASE: if (!resp_req) nxt_state = IDLE;
            default: nxt_state = IDLE;
        endcase
    end

    // Byte captured as the request is seen, ready before trmt
    always_ff @(posedge clk) begin
        if ((state == IDLE) && resp_req)
            tx_data <= uart_pkg::uart_byte_t'(resp);
    end

endmodule

/* design/uart_cmd_link.sv */
/*
 UART command link top level.
 Serial RX bytes are paired into 16-bit commands for the host; host
 response bytes go back out on TX. Both host channels are four-phase
 req/ack, and the two directions run independently.
*/
`timescale 1ns/1ps

module uart_cmd_link (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           RX,        // Serial in, idle high
    output logic           TX,        // Serial out, idle high
    output cmd_pkg::cmd_t  cmd,       // Op high byte, arg low byte
    output logic           cmd_req,
    input  logic           cmd_ack,
    input  cmd_pkg::resp_t resp,
    input  logic           resp_req,
    output logic           resp_ack
);

    // Receive path
    uart_pkg::uart_byte_t rx_data;
    logic                 rdy;
    logic                 clr_rdy;

    // Transmit path
    uart_pkg::uart_byte_t tx_data;
    logic                 trmt;
    logic                 tx_done;

    uart_rx uart_rx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .RX      (RX),
        .clr_rdy (clr_rdy),
        .rx_data (rx_data),
        .rdy     (rdy)
    );

    cmd_assembler cmd_assembler_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_data (rx_data),
        .rdy     (rdy),
        .clr_rdy (clr_rdy),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack)
    );

    resp_sender resp_sender_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .resp     (resp),
        .resp_req (resp_req),
        .resp_ack (resp_ack),
        .tx_data  (tx_data),
        .trmt     (trmt),
        .tx_done  (tx_done)
    );

    uart_tx uart_tx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .trmt    (trmt),
        .tx_data (tx_data),
        .TX      (TX),
        .tx_done (tx_done)
    );

endmodule

/* design/uart_pkg.sv */
/*
 Serial line description for the UART command link.
 Holds the clock and baud figures, the frame layout and the vector types
 used by the transmitter, the receiver and the testbench.
 Referenced by scoped names only; change CLK_HZ or BAUD here and every
 counter that depends on them follows.
*/
package uart_pkg;

    // System clock and line rate
    localparam int CLK_HZ = 50_000_000;
    localparam int BAUD   = 19_200;

    // Clock cycles per serial bit, 2604 at 50 MHz / 19200
    localparam int BIT_CYCLES = CLK_HZ / BAUD;

    // First receiver sample lands mid start bit
    localparam int HALF_BIT = BIT_CYCLES / 2;

    // Start, eight data bits, stop
    localparam int FRAME_BITS = 10;

    // One data byte on the line
    typedef logic [7:0] uart_byte_t;

    // Baud counter, wide enough for BIT_CYCLES
    typedef logic [11:0] baud_cnt_t;

    // Bit counter, wide enough for FRAME_BITS
    typedef logic [3:0] bit_cnt_t;

endpackage

/* design/uart_rx.sv */
/*
 UART receiver, 8 data bits, no parity, one stop bit.
 RX is synchronized, a falling edge in idle starts a frame, and each bit is
 sampled near its middle: HALF_BIT cycles in, then every BIT_CYCLES.
 rdy is set at mid stop bit only when the stop bit is high, and is held
 until a clr_rdy pulse or the next start bit.
*/
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 RX,       // Asynchronous serial in
    input  logic                 clr_rdy,  // One-cycle acknowledge of rx_data
    output uart_pkg::uart_byte_t rx_data,  // Last good byte
    output logic                 rdy       // rx_data holds a new byte
);

    // IDLE watches for a start edge, RECEIVE samples the frame
    typedef enum logic {IDLE, RECEIVE} state_t;
    state_t state, nxt_state;

    logic                rx_meta;    // First synchronizer stage
    logic                rx_sync;    // Safe to use
    logic                rx_prev;    // For edge detection
    logic                start;      // Falling edge while idle
    logic                receiving;
    logic                sample;     // Bit center reached
    logic                last_bit;   // Stop bit sample
    uart_pkg::baud_cnt_t baud_cnt;
    uart_pkg::bit_cnt_t  bit_cnt;    // Samples taken this frame
    logic [8:0]          rx_shift;   // Start bit ends in bit 0

    // Double flop plus one more stage to see the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= RX;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign receiving = (state == RECEIVE);
    assign start     = (state == IDLE) && rx_prev && !rx_sync;
    assign sample    = receiving && (baud_cnt == '0);
    assign last_bit  = sample &&
                       (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            IDLE:    if (start) nxt_state = RECEIVE;
            RECEIVE: if (last_bit) nxt_state = IDLE;  // Rest of stop bit is idle
            default: nxt_state = IDLE;
        endcase
    end

    // Half a bit to the start bit center, whole bits after that
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            baud_cnt <= '0;
        else if (start)
            baud_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::HALF_BIT - 1);
        else if (sample)
            baud_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BIT_CYCLES - 1);
        else if (receiving)
            baud_cnt <= baud_cnt - 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (start)
            bit_cnt <= '0;
        else if (sample)
            bit_cnt <= bit_cnt + 1'b1;
    end

    // LSB arrives first, shift right; stop bit is checked, not stored
    always_ff @(posedge clk) begin
        if (sample && !last_bit)
            rx_shift <= {rx_sync, rx_shift[8:1]};
    end

    assign rx_data = rx_shift[8:1];

    // Low stop bit leaves rdy clear, frame dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rdy <= 1'b0;
        else if (last_bit && rx_sync)
            rdy <= 1'b1;
        else if (start || clr_rdy)
            rdy <= 1'b0;  // New frame overwrites an unread byte
    end

endmodule

/* design/uart_tx.sv */
/*
 UART transmitter, 8 data bits, no parity, one stop bit.
 A one-cycle trmt pulse starts a frame using tx_data; TX drops for the start
 bit on the next cycle and each bit lasts BIT_CYCLES clocks, LSB first.
 tx_done rises as the stop bit ends and stays high until the next trmt.
*/
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 trmt,     // One-cycle start request
    input  uart_pkg::uart_byte_t tx_data,  // Byte to send, taken with trmt
    output logic                 TX,       // Serial out, idle high
    output logic                 tx_done   // Held from end of frame to next trmt
);

    // IDLE waits for trmt, TRANSMIT walks through the ten bits
    typedef enum logic {IDLE, TRANSMIT} state_t;
    state_t state, nxt_state;

    logic                init;          // Load a new frame
    logic                shift;         // Bit period over, move to next bit
    logic                frame_end;     // Last shift, stop bit complete
    logic                transmitting;  // Counting bit time
    uart_pkg::baud_cnt_t baud_cnt;      // Cycles left in current bit
    uart_pkg::bit_cnt_t  bit_cnt;       // Bits already sent
    logic [8:0]          tx_shift;      // Data plus start bit, LSB on the line

    assign transmitting = (state == TRANSMIT);
    assign shift        = transmitting && (baud_cnt == '0);
    assign frame_end    = shift &&
                          (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::FRAME_BITS - 1));

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= nxt_state;
    end

    always_comb begin
        init      = 1'b0;
        nxt_state = state;
        case (state)
            IDLE: begin
                if (trmt) begin
                    init      = 1'b1;
                    nxt_state = TRANSMIT;
                end
            end
            TRANSMIT: begin
                if (frame_end)
                    nxt_state = IDLE;  // Back to idle as tx_done sets
            end
            default: nxt_state = IDLE;
        endcase
    end

    // Baud counter, reloaded on every bit boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            baud_cnt <= '0;
        else if (init || shift)
            baud_cnt <= uart_pkg::baud_cnt_t'(uart_pkg::BIT_CYCLES - 1);
        else if (transmitting)
            baud_cnt <= baud_cnt - 1'b1;
    end

    // Bits sent so far, frame ends at FRAME_BITS
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (init)
            bit_cnt <= '0;
        else if (shift)
            bit_cnt <= bit_cnt + 1'b1;
    end

    // Ones fill in from the top, so the stop bit and idle come for free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tx_shift <= '1;                        // Line idles high
        else if (init)
            tx_shift <= {tx_data, 1'b0};           // Start bit first
        else if (shift)
            tx_shift <= {1'b1, tx_shift[8:1]};
    end

    assign TX = tx_shift[0];

    // Set/reset flag: cleared by a new frame, set when the frame is out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tx_done <= 1'b0;
        else if (init)
            tx_done <= 1'b0;
        else if (frame_end)
            tx_done <= 1'b1;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into sim.log, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_uart_cmd_link -f vlog.f \
        -o tb_uart_cmd_link > sim.log 2>&1 &&
    ./obj_dir/tb_uart_cmd_link >> sim.log 2>&1 ||
    { cat sim.log; echo "Build or simulation run did not complete"; exit 1; }
tail -n 12 sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* testbench/tb_serial_model.svh */
/*
 Serial line model for the UART command link testbench.
 Included inside the testbench module. Drives frames onto RX and decodes
 frames from TX at the package baud, sampling on falling clock edges.
 Uses clk, RX, TX and flag_error of the including module.
*/
`ifndef TB_SERIAL_MODEL_SVH
`define TB_SERIAL_MODEL_SVH

// One frame on RX: start, eight data bits LSB first, then the given stop level
task automatic send_frame(input uart_pkg::uart_byte_t data, input logic stop_bit);
    int i;
    RX = 1'b0;                                   // Start bit
    repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    for (i = 0; i < 8; i++) begin
        RX = data[i];
        repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    end
    RX = stop_bit;                               // Low here makes a framing error
    repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    RX = 1'b1;
    // After a low stop bit the line needs an idle bit before the next start edge
    if (!stop_bit)
        repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
endtask

// Decode one TX frame, each bit sampled at the middle of its period
task automatic read_frame(output uart_pkg::uart_byte_t data);
    int i;
    @(negedge TX);                               // Start bit edge
    repeat (uart_pkg::HALF_BIT) @(negedge clk);
    assert (TX == 1'b0)
        else flag_error("start bit not low at its middle");
    for (i = 0; i < 8; i++) begin
        repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
        data[i] = TX;                            // LSB first
    end
    repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    assert (TX == 1'b1)
        else flag_error("stop bit on TX is low");
endtask

`endif

/* testbench/tb_uart_cmd_link.sv */
/*
 Testbench for the UART command link.
 Sends two-byte commands on RX and checks them at the host port with
 concurrent assertions; writes response bytes and decodes them from TX.
 A host model acks commands after a random delay below one frame.
 One line per test, then a summary line.
*/
`timescale 1ns/1ps

module tb_uart_cmd_link;

    localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::BIT_CYCLES;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 40 * FRAME_CYCLES + RESET_CYCLES;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           RX;
    logic           TX;
    cmd_pkg::cmd_t  cmd;
    logic           cmd_req;
    logic           cmd_ack;
    cmd_pkg::resp_t resp;
    logic           resp_req;
    logic           resp_ack;

    cmd_pkg::cmd_t  exp_q[$];            // Sent and not yet acked by the host
    cmd_pkg::cmd_t  exp_cmd;             // Head of exp_q
    logic           exp_valid = 1'b0;
    logic           late_ack  = 1'b0;    // Host waits nearly a full frame
    int             seed      = 32'h7e2d;
    int             errors    = 0;
    int             req_cnt   = 0;       // cmd_req rises seen by the host
    int             pass_cnt  = 0;
    int             fail_cnt  = 0;
    int             cycles    = 0;

    always #5 clk = ~clk;                // 100 MHz sim clock with a 10 ns period

    uart_cmd_link uart_cmd_link_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .RX       (RX),
        .TX       (TX),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .resp     (resp),
        .resp_req (resp_req),
        .resp_ack (resp_ack)
    );

    task automatic flag_error(input string msg);
        errors++;
        $display("FAILED %0t ns: %s", $time, msg);
    endtask

    `include "tb_serial_model.svh"

    // Word on cmd must be the oldest pair still outstanding
    cmd_matches: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_req) |-> (exp_valid && cmd == exp_cmd))
        else flag_error($sformatf("cmd %h at cmd_req rise, expected %h", cmd, exp_cmd));

    // Data may only move once req and ack are both low
    cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_req || cmd_ack) |=> $stable(cmd))
        else flag_error("cmd changed during the handshake");

    // Once raised, cmd_req stays up until the host acks
    req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_req && !cmd_ack |=> cmd_req)
        else flag_error("cmd_req fell before cmd_ack rose");

    // resp_ack holds while the host still requests
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        resp_ack && resp_req |=> resp_ack)
        else flag_error("resp_ack fell while resp_req was high");

    // Host end of the command channel
    initial begin : host_model
        int unsigned dly;
        cmd_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (cmd_req) begin
                req_cnt++;
                if (late_ack)
                    dly = FRAME_CYCLES - 1 - ($unsigned($random(seed)) % 4);
                else
                    dly = $unsigned($random(seed)) % FRAME_CYCLES;
                repeat (dly) @(negedge clk);
                cmd_ack = 1'b1;
                while (cmd_req) @(negedge clk);
                cmd_ack = 1'b0;             // Both low so the word is consumed
                if (exp_q.size() > 0)
                    void'(exp_q.pop_front());
                exp_valid = (exp_q.size() > 0);
                if (exp_valid)
                    exp_cmd = exp_q[0];
            end
        end
    end

    // Ends a hung run
    initial begin : watchdog
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic expect_cmd(input cmd_pkg::cmd_op_t op, input cmd_pkg::cmd_arg_t arg);
        exp_q.push_back({op, arg});
        exp_cmd   = exp_q[0];
        exp_valid = 1'b1;
    endtask

    task automatic send_cmd(input uart_pkg::uart_byte_t op, input uart_pkg::uart_byte_t arg);
        expect_cmd(op, arg);
        send_frame(op, 1'b1);
        send_frame(arg, 1'b1);
    endtask

    task automatic wait_cmds_done();
        while (exp_q.size() > 0) @(negedge clk);
    endtask

    // Four-phase write of one response checked on TX
    task automatic send_resp(input cmd_pkg::resp_t r);
        uart_pkg::uart_byte_t got;
        int                   n;
        resp     = r;
        resp_req = 1'b1;
        read_frame(got);                  // Returns at mid stop bit
        assert (got == r)
            else flag_error($sformatf("TX byte %h, expected %h", got, r));
        n = 0;
        while (!resp_ack) begin
            @(negedge clk);
            n++;
        end
        assert (n > uart_pkg::HALF_BIT)   // Stop bit still had half a bit to run
            else flag_error("resp_ack rose before the stop bit ended");
        resp_req = 1'b0;
        while (resp_ack) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int start_err);
        if (errors == start_err) begin
            pass_cnt++;
            $display("%0t ns  %s: ok", $time, name);
        end else begin
            fail_cnt++;
            $display("%0t ns  %s: %0d errors", $time, name, errors - start_err);
        end
    endtask

    initial begin : stimulus
        uart_pkg::uart_byte_t op;
        uart_pkg::uart_byte_t arg;
        int                   start_err;
        int                   req_before;
        int                   i;
        rst_n    = 1'b0;
        RX       = 1'b1;                  // Line idle
        resp     = '0;
        resp_req = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        start_err = errors;
        assert (TX && !cmd_req && !resp_ack)
            else flag_error("TX, cmd_req or resp_ack not idle after reset");
        end_test("reset_idle", start_err);

        start_err = errors;
        send_cmd(8'hA5, 8'h3C);
        wait_cmds_done();
        end_test("single_cmd", start_err);

        // Next op byte has to wait in the receiver while the host is slow
        start_err = errors;
        late_ack  = 1'b1;
        for (i = 0; i < 8; i++) begin
            op  = 8'($random(seed));
            arg = 8'($random(seed));
            send_cmd(op, arg);
        end
        wait_cmds_done();
        late_ack = 1'b0;
        end_test("burst_late_ack", start_err);

        start_err = errors;
        send_resp(8'h5A);
        for (i = 0; i < 2; i++)
            send_resp(8'($random(seed)));
        end_test("responses", start_err);

        // Bad frame between op and arg must leave the pair intact
        start_err  = errors;
        op         = 8'($random(seed));
        arg        = 8'($random(seed));
        expect_cmd(op, arg);
        send_frame(op, 1'b1);
        req_before = req_cnt;
        send_frame(8'($random(seed)), 1'b0);
        assert (req_cnt == req_before)
            else flag_error("frame with low stop bit produced a cmd_req");
        send_frame(arg, 1'b1);
        send_cmd(8'($random(seed)), 8'($random(seed)));
        wait_cmds_done();
        end_test("framing_error", start_err);

        start_err = errors;
        fork
            send_cmd(8'h12, 8'hED);
            send_resp(8'hC3);
        join
        wait_cmds_done();
        end_test("both_directions", start_err);

        $display("Summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
design/uart_pkg.sv
design/cmd_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/cmd_assembler.sv
design/resp_sender.sv
design/uart_cmd_link.sv
testbench/tb_uart_cmd_link.sv
